//--- cart_pkg.sv
// Cartridge loader shared definitions
// Download stream bus, region selection types, cheat code layout
// and the backup RAM sector request
`default_nettype none

package cart_pkg;

	//////////////////////////////
	// Download stream
	localparam int DL_ADDR_W  = 25;
	localparam int DL_DATA_W  = 16;
	localparam int DL_INDEX_W = 8;

	// Header word addresses, byte addressed
	localparam logic [DL_ADDR_W-1:0] HDR_REGION_ADDR  = 25'h1F0;
	localparam logic [DL_ADDR_W-1:0] HDR_REGION2_ADDR = 25'h1F2;
	localparam logic [DL_ADDR_W-1:0] HDR_END_ADDR     = 25'h200; // Header fully seen

	// Backup RAM geometry
	localparam int BK_SECTORS = 128;
	localparam int LBA_W      = 7;

	// Cheat code is eight half-words, last one at offset 14
	localparam int          CHEAT_WORDS    = 8;
	localparam logic [3:0]  CHEAT_LAST_OFS = 4'((CHEAT_WORDS - 1) * 2);

	//////////////////////////////
	// Types
	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_t;

	typedef enum logic [1:0] {
		PRIO_US_EU_JP = 2'd0,
		PRIO_EU_US_JP = 2'd1,
		PRIO_US_JP_EU = 2'd2,
		PRIO_JP_US_EU = 2'd3
	} prio_t;

	// Region flags seen in the header
	typedef struct packed {
		logic e;
		logic u;
		logic j;
	} hdr_flags_t;

	typedef struct packed {
		logic                 cart;  // Cart download active
		logic                 code;  // Code download active
		logic                 wr;    // Write strobe
		logic [DL_ADDR_W-1:0] addr;
		logic [DL_DATA_W-1:0] data;
		logic [1:0]           idx;   // Top bits of download index
	} dl_bus_t;

	typedef struct packed {
		logic        valid; // Strobe
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic             rd;
		logic             wr;
		logic [LBA_W-1:0] lba;
	} sd_req_t;

endpackage

`default_nettype wire

//--- sector_counter.sv
// Backup sector address counter
// Cleared at transfer start, advanced per finished sector, flags
// the final sector of the backup image
`default_nettype none

module sector_counter import cart_pkg::*; (
	input  wire              clk_sys,
	input  wire              RESET,
	input  wire              clear,
	input  wire              advance,
	output logic [LBA_W-1:0] lba,
	output logic             last
);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			lba <= '0;
		end else if (clear) begin
			lba <= '0;
		end else if (advance) begin
			lba <= lba + 1'b1;
		end
	end

	assign last = (lba == LBA_W'(BK_SECTORS - 1)); // Final sector

endmodule

`default_nettype wire

//--- header_region.sv
// Cartridge header region parser
// Collects J/U/E region flags from the ROM header while the cart
// downloads, then strobes one region request when the header is
// complete, either by priority order or from the download index
`default_nettype none

module header_region import cart_pkg::*; (
	input  wire          clk_sys,
	input  wire          RESET,
	input  wire dl_bus_t dl,
	input  wire          auto_region,
	input  wire          region_from_hdr,
	input  wire prio_t   region_prio,
	output region_t      region_req,
	output logic         region_set
);

	logic       hdr_wr;
	logic [7:0] lo_ch;
	logic [7:0] hi_ch;
	logic [3:0] hex_rgn;
	hdr_flags_t lo_letter;
	hdr_flags_t hi_letter;
	hdr_flags_t flags;
	hdr_flags_t flags_nxt;
	logic [1:0] idx_r;
	logic       cart_q;
	logic       hdr_ready;
	logic       ready_q;
	logic       ready_rise;

	// One flag per region letter, none for anything else
	function automatic hdr_flags_t letter_flag(input logic [7:0] ch);
		hdr_flags_t f;
		f = '0;
		case (ch)
			"J": f.j = 1'b1;
			"U": f.u = 1'b1;
			"E": f.e = 1'b1;
			default: ;
		endcase
		return f;
	endfunction

	// First flagged region in priority order, else the order's head
	function automatic region_t pick_region(input hdr_flags_t f, input prio_t p);
		region_t r;
		r = REGION_US;
		case (p)
			PRIO_US_EU_JP: r = f.u ? REGION_US : f.e ? REGION_EU :
				f.j ? REGION_JP : REGION_US;
			PRIO_EU_US_JP: r = f.e ? REGION_EU : f.u ? REGION_US :
				f.j ? REGION_JP : REGION_EU;
			PRIO_US_JP_EU: r = f.u ? REGION_US : f.j ? REGION_JP :
				f.e ? REGION_EU : REGION_US;
			PRIO_JP_US_EU: r = f.j ? REGION_JP : f.u ? REGION_US :
				f.e ? REGION_EU : REGION_JP;
		endcase
		return r;
	endfunction

	assign hdr_wr    = dl.cart & dl.wr;
	assign lo_ch     = dl.data[7:0];
	assign hi_ch     = dl.data[15:8];
	assign hex_rgn   = dl.data[3:0] - 4'd7; // 'A'..'F' to 10..15
	assign lo_letter = letter_flag(lo_ch);
	assign hi_letter = letter_flag(hi_ch);

	//////////////////////////////
	// Flag update from header writes
	always_comb begin
		flags_nxt = flags;
		if (hdr_wr && (dl.addr == HDR_REGION_ADDR)) begin
			if (lo_letter != '0) begin
				flags_nxt = flags | lo_letter;
			end else if (lo_ch >= "0" && lo_ch <= "9") begin
				flags_nxt = '{e: lo_ch[3], u: lo_ch[2], j: lo_ch[0]}; // Bit coded
			end else if (lo_ch >= "A" && lo_ch <= "F") begin
				flags_nxt = '{e: hex_rgn[3], u: hex_rgn[2], j: hex_rgn[0]};
			end
			flags_nxt = flags_nxt | hi_letter; // High byte is letters only
		end else if (hdr_wr && (dl.addr == HDR_REGION2_ADDR)) begin
			flags_nxt = flags | lo_letter;
		end
	end

	assign ready_rise = hdr_ready & ~ready_q;

	//////////////////////////////
	// Download tracking and strobe
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_q     <= 1'b0;
			hdr_ready  <= 1'b0;
			ready_q    <= 1'b0;
			region_set <= 1'b0;
		end else begin
			cart_q  <= dl.cart;
			ready_q <= hdr_ready;
			if (cart_q & ~dl.cart) begin
				hdr_ready <= 1'b0; // Download over
			end else if (hdr_wr && (dl.addr == HDR_END_ADDR)) begin
				hdr_ready <= 1'b1;
			end
			// Index mode only strobes for a non-zero index
			region_set <= ready_rise & auto_region & (region_from_hdr | (idx_r != 2'd0));
		end
	end

	always_ff @(posedge clk_sys) begin
		if (dl.cart & ~cart_q) begin
			flags <= '0;
			idx_r <= dl.idx;
		end else begin
			flags <= flags_nxt;
		end
		if (ready_rise) begin
			region_req <= region_from_hdr ? pick_region(flags, region_prio) : region_t'(idx_r);
		end
	end

endmodule

`default_nettype wire

//--- cheat_loader.sv
// Cheat code loader
// Assembles eight 16-bit download words into one 128-bit cheat
// code and strobes it out with the last word
`default_nettype none

module cheat_loader import cart_pkg::*; (
	input  wire          clk_sys,
	input  wire          RESET,
	input  wire dl_bus_t dl,
	output cheat_code_t  cheat
);

	logic        code_wr;
	logic        valid_r;
	logic [31:0] flags_r;
	logic [31:0] address_r;
	logic [31:0] compare_r;
	logic [31:0] replace_r;

	assign code_wr = dl.code & dl.wr;

	// Half-word placement by offset within the code
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl.addr[3:0])
				4'd0:           flags_r[15:0]    <= dl.data;
				4'd2:           flags_r[31:16]   <= dl.data;
				4'd4:           address_r[15:0]  <= dl.data;
				4'd6:           address_r[31:16] <= dl.data;
				4'd8:           compare_r[15:0]  <= dl.data;
				4'd10:          compare_r[31:16] <= dl.data;
				4'd12:          replace_r[15:0]  <= dl.data;
				CHEAT_LAST_OFS: replace_r[31:16] <= dl.data; // Completes the code
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			valid_r <= 1'b0;
		end else begin
			valid_r <= code_wr & (dl.addr[3:0] == CHEAT_LAST_OFS);
		end
	end

	assign cheat = '{
		valid:   valid_r,
		flags:   flags_r,
		address: address_r,
		compare: compare_r,
		replace: replace_r
	};

endmodule

`default_nettype wire

//--- backup_fsm.sv
// Backup RAM load/save sequencer
// Walks all backup sectors through the host's level request and
// acknowledge handshake, reading on load and writing on save
`default_nettype none

module backup_fsm import cart_pkg::*; (
	input  wire          clk_sys,
	input  wire          RESET,
	input  wire dl_bus_t dl,
	input  wire          sd_ack,
	input  wire          img_mounted,
	input  wire          img_readonly,
	input  wire          img_present,
	input  wire          bk_load,
	input  wire          bk_save,
	output sd_req_t      sd,
	output logic         busy
);

	typedef enum logic [1:0] {
		IDLE,
		REQUEST,  // rd or wr held
		WAIT_ACK  // Waiting for ack to drop
	} state_t;

	state_t           state;
	logic             enable;
	logic             loading;
	logic             cart_q;
	logic             cart_q2;
	logic             load_q;
	logic             load_q2;
	logic             save_q;
	logic             save_q2;
	logic             ack_q;
	logic             load_edge;
	logic             save_edge;
	logic             dl_done;
	logic             start;
	logic             ack_rise;
	logic             ack_fall;
	logic             last;
	logic [LBA_W-1:0] lba;

	//////////////////////////////
	// Input registers and edges
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_q  <= 1'b0;
			cart_q2 <= 1'b0;
			load_q  <= 1'b0;
			load_q2 <= 1'b0;
			save_q  <= 1'b0;
			save_q2 <= 1'b0;
			ack_q   <= 1'b0;
		end else begin
			cart_q  <= dl.cart;
			cart_q2 <= cart_q;
			load_q  <= bk_load;
			load_q2 <= load_q;
			save_q  <= bk_save;
			save_q2 <= save_q;
			ack_q   <= sd_ack;
		end
	end

	assign load_edge = load_q & ~load_q2;
	assign save_edge = save_q & ~save_q2;
	assign dl_done   = cart_q2 & ~cart_q & enable & img_present; // Load after cart
	assign start     = dl_done | (enable & (load_edge | save_edge));
	assign ack_rise  = sd_ack & ~ack_q;
	assign ack_fall  = ack_q & ~sd_ack;

	// Save image gets mounted while the cart is downloading
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			enable <= 1'b0;
		end else if (dl.cart & img_mounted & ~img_readonly) begin
			enable <= 1'b1;
		end else if (dl.cart & ~cart_q) begin
			enable <= 1'b0;
		end
	end

	//////////////////////////////
	// Sequencer
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state   <= IDLE;
			loading <= 1'b0;
		end else begin
			case (state)
				IDLE: if (start) begin
					state   <= REQUEST;
					loading <= dl_done | load_edge; // Load wins over save
				end
				REQUEST: if (ack_rise) state <= WAIT_ACK;
				WAIT_ACK: if (ack_fall) state <= last ? IDLE : REQUEST;
				default: state <= IDLE;
			endcase
		end
	end

	sector_counter u_sector_counter (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.clear   ((state == IDLE) & start),
		.advance ((state == WAIT_ACK) & ack_fall & ~last),
		.lba     (lba),
		.last    (last)
	);

	assign sd.rd  = (state == REQUEST) & loading;
	assign sd.wr  = (state == REQUEST) & ~loading;
	assign sd.lba = lba;
	assign busy   = (state != IDLE);

endmodule

`default_nettype wire

//--- cart_loader.sv
// Cartridge load top level
// Splits the host download stream into cart and code downloads and
// feeds the header region parser, cheat loader and backup sequencer
`default_nettype none

module cart_loader import cart_pkg::*; (
	input  wire                  clk_sys,
	input  wire                  RESET,
	input  wire                  dl_active,
	input  wire                  dl_wr,
	input  wire [DL_ADDR_W-1:0]  dl_addr,
	input  wire [DL_DATA_W-1:0]  dl_data,
	input  wire [DL_INDEX_W-1:0] dl_index,
	input  wire                  sd_ack,
	input  wire                  img_mounted,
	input  wire                  img_readonly,
	input  wire                  img_present,
	input  wire                  bk_load,
	input  wire                  bk_save,
	input  wire                  auto_region,
	input  wire                  region_from_hdr,
	input  wire prio_t           region_prio,
	output region_t              region_req,
	output logic                 region_set,
	output cheat_code_t          cheat,
	output sd_req_t              sd,
	output logic                 busy
);

	dl_bus_t dl;
	logic    code_index;

	assign code_index = &dl_index; // All ones selects the cheat file

	always_comb begin
		dl.cart = dl_active & ~code_index;
		dl.code = dl_active & code_index;
		dl.wr   = dl_wr;
		dl.addr = dl_addr;
		dl.data = dl_data;
		dl.idx  = dl_index[DL_INDEX_W-1 -: 2];
	end

	//////////////////////////////
	header_region u_header_region (
		.clk_sys         (clk_sys),
		.RESET           (RESET),
		.dl              (dl),
		.auto_region     (auto_region),
		.region_from_hdr (region_from_hdr),
		.region_prio     (region_prio),
		.region_req      (region_req),
		.region_set      (region_set)
	);

	cheat_loader u_cheat_loader (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.dl      (dl),
		.cheat   (cheat)
	);

	backup_fsm u_backup_fsm (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.dl           (dl),
		.sd_ack       (sd_ack),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_present  (img_present),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.sd           (sd),
		.busy         (busy)
	);

endmodule

`default_nettype wire

//--- cart_loader_checker.sv
// Cartridge loader handshake assertions
// Bound into the top level, checks strobe width and sector handshake
`default_nettype none

module cart_loader_checker import cart_pkg::*; (
	input wire          clk_sys,
	input wire          RESET,
	input wire sd_req_t sd,
	input wire          sd_ack,
	input wire          busy,
	input wire          region_set,
	input wire          cheat_valid
);

	// Request holds until the host acknowledges
	a_rd_hold: assert property (@(posedge clk_sys) disable iff (RESET)
		(sd.rd && !sd_ack) |=> sd.rd) else $error("rd dropped before ack");
	a_wr_hold: assert property (@(posedge clk_sys) disable iff (RESET)
		(sd.wr && !sd_ack) |=> sd.wr) else $error("wr dropped before ack");
	a_req_release: assert property (@(posedge clk_sys) disable iff (RESET)
		((sd.rd || sd.wr) && sd_ack) |=> !(sd.rd || sd.wr))
		else $error("request still held after ack");
	a_busy: assert property (@(posedge clk_sys) disable iff (RESET)
		(sd.rd || sd.wr) |-> busy) else $error("request while not busy");
	a_region_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		region_set |=> !region_set) else $error("region strobe too long");
	a_cheat_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		cheat_valid |=> !cheat_valid) else $error("cheat strobe too long");

endmodule

`default_nettype wire

//--- cart_monitor.sv
// Cartridge loader response monitor
// Compares region strobes, cheat codes and sector requests against
// expectations queued by the testbench, and counts mismatches
`default_nettype none

module cart_monitor import cart_pkg::*; (
	input wire              clk_sys,
	input wire              RESET,
	input wire region_t     region_req,
	input wire              region_set,
	input wire cheat_code_t cheat,
	input wire sd_req_t     sd
);

	longint      cyc = 0;       // Clock count, stimulus reads it
	int          region_errs = 0;
	int          cheat_errs = 0;
	int          sd_errs = 0;
	logic        req_q = 1'b0;
	region_t     region_q[$];
	longint      region_at_q[$];
	cheat_code_t cheat_q[$];
	longint      cheat_at_q[$];
	sd_req_t     sd_q[$];
	region_t     exp_rgn;
	cheat_code_t exp_code;
	sd_req_t     exp_sd;
	longint      exp_at;

	task automatic push_region(input region_t r, input longint at);
		region_q.push_back(r);
		region_at_q.push_back(at);
	endtask

	task automatic push_cheat(input cheat_code_t c, input longint at);
		cheat_q.push_back(c);
		cheat_at_q.push_back(at);
	endtask

	task automatic push_sector(input sd_req_t s);
		sd_q.push_back(s);
	endtask

	function automatic int pending();
		return region_q.size() + cheat_q.size() + sd_q.size();
	endfunction

	//////////////////////////////
	// Sampled on the clock edge, outputs are settled
	always @(posedge clk_sys) begin
		cyc <= cyc + 1;
		req_q <= sd.rd | sd.wr;
		if (!RESET) begin
			if (region_set) begin
				if (region_q.size() == 0) begin
					$display("FAIL t=%0t: unexpected region strobe, region %0d", $time, region_req);
					region_errs++;
				end else begin
					exp_rgn = region_q.pop_front();
					exp_at  = region_at_q.pop_front();
					if (region_req !== exp_rgn || cyc != exp_at) begin
						$display("FAIL t=%0t: region %0d at cycle %0d, expected %0d at %0d",
							$time, region_req, cyc, exp_rgn, exp_at);
						region_errs++;
					end
				end
			end
			if (cheat.valid) begin
				if (cheat_q.size() == 0) begin
					$display("FAIL t=%0t: unexpected cheat strobe", $time);
					cheat_errs++;
				end else begin
					exp_code = cheat_q.pop_front();
					exp_at   = cheat_at_q.pop_front();
					if (cheat !== exp_code || cyc != exp_at) begin
						$display("FAIL t=%0t: cheat %h at cycle %0d, expected %h at %0d",
							$time, cheat, cyc, exp_code, exp_at);
						cheat_errs++;
					end
				end
			end
			if (sd.rd & sd.wr) begin
				$display("FAIL t=%0t: rd and wr requested together", $time);
				sd_errs++;
			end
			if ((sd.rd | sd.wr) && !req_q) begin // New sector request
				if (sd_q.size() == 0) begin
					$display("FAIL t=%0t: unexpected sector request lba %0d", $time, sd.lba);
					sd_errs++;
				end else begin
					exp_sd = sd_q.pop_front();
					if (sd !== exp_sd) begin
						$display("FAIL t=%0t: sector req rd %b wr %b lba %0d, expected %b %b %0d",
							$time, sd.rd, sd.wr, sd.lba, exp_sd.rd, exp_sd.wr, exp_sd.lba);
						sd_errs++;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tb_cart_loader.sv
// Cartridge loader testbench
// Drives header, cheat and backup scenarios, models the host
// sector interface and reports the overall result
`default_nettype none

module tb_cart_loader import cart_pkg::*; ();

	localparam int MAX_SECTOR_CYC = 14;  // Ack delay, hold and re-request
	localparam int N_DOWNLOADS    = 60;
	localparam int DL_CYC         = 40;
	localparam int WD_CYCLES = (2 * BK_SECTORS * MAX_SECTOR_CYC + N_DOWNLOADS * DL_CYC) * 2;

	logic            clk_sys;
	logic            RESET;
	logic            dl_active;
	logic            dl_wr;
	logic [24:0]     dl_addr;
	logic [15:0]     dl_data;
	logic [7:0]      dl_index;
	logic            sd_ack;
	logic            img_mounted;
	logic            img_readonly;
	logic            img_present;
	logic            bk_load;
	logic            bk_save;
	logic            auto_region;
	logic            region_from_hdr;
	prio_t           region_prio;
	region_t         region_req;
	logic            region_set;
	cheat_code_t     cheat;
	sd_req_t         sd;
	logic            busy;
	int              other_errs = 0;

	cart_loader DUT (.*);

	cart_monitor mon (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.region_req (region_req),
		.region_set (region_set),
		.cheat      (cheat),
		.sd         (sd)
	);

	bind cart_loader cart_loader_checker u_checker (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.sd          (sd),
		.sd_ack      (sd_ack),
		.busy        (busy),
		.region_set  (region_set),
		.cheat_valid (cheat.valid)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	initial begin
		repeat (WD_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired, the run did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

	//////////////////////////////
	// Reference models
	function automatic region_t expected_region(input logic [7:0] lo0, input logic [7:0] hi0,
			input logic [7:0] lo2, input prio_t p);
		logic [2:0] f;   // e, u, j
		logic [7:0] h;
		region_t    ord[3];
		f = 3'b000;
		h = lo0 - 8'h37;
		if (lo0 == "J") f[0] = 1'b1;
		else if (lo0 == "U") f[1] = 1'b1;
		else if (lo0 == "E") f[2] = 1'b1;
		else if (lo0 >= "0" && lo0 <= "9") f = {lo0[3], lo0[2], lo0[0]};
		else if (lo0 >= "A" && lo0 <= "F") f = {h[3], h[2], h[0]};
		if (hi0 == "J" || lo2 == "J") f[0] = 1'b1;
		if (hi0 == "U" || lo2 == "U") f[1] = 1'b1;
		if (hi0 == "E" || lo2 == "E") f[2] = 1'b1;
		case (p)
			PRIO_US_EU_JP: ord = '{REGION_US, REGION_EU, REGION_JP};
			PRIO_EU_US_JP: ord = '{REGION_EU, REGION_US, REGION_JP};
			PRIO_US_JP_EU: ord = '{REGION_US, REGION_JP, REGION_EU};
			default:       ord = '{REGION_JP, REGION_US, REGION_EU};
		endcase
		for (int i = 0; i < 3; i++) begin
			if (f[ord[i]]) return ord[i]; // Region value indexes its flag
		end
		return ord[0];
	endfunction

	function automatic cheat_code_t expected_cheat(input logic [15:0] w [CHEAT_WORDS]);
		cheat_code_t c;
		c.valid   = 1'b1;
		c.flags   = {w[1], w[0]};
		c.address = {w[3], w[2]};
		c.compare = {w[5], w[4]};
		c.replace = {w[7], w[6]};
		return c;
	endfunction

	//////////////////////////////
	// Stimulus helpers
	task automatic step();
		@(posedge clk_sys);
		#10;
	endtask

	task automatic cart_download(input logic [7:0] index, input logic [15:0] w0,
			input logic [15:0] w2, input logic mount, input logic strobe, input region_t rgn);
		logic [24:0] a;
		dl_index    = index;
		dl_active   = 1'b1;
		img_mounted = mount;
		step();
		for (a = 25'h1E8; a <= HDR_END_ADDR; a = a + 25'd2) begin
			dl_addr = a;
			if (a == HDR_REGION_ADDR) dl_data = w0;
			else if (a == HDR_REGION2_ADDR) dl_data = w2;
			else dl_data = 16'($urandom);
			dl_wr = 1'b1;
			if (a == HDR_END_ADDR && strobe) mon.push_region(rgn, mon.cyc + 2);
			step();
			dl_wr = 1'b0;
			step();
		end
		repeat (4) step();
		dl_active   = 1'b0;
		img_mounted = 1'b0;
		repeat (6) step();
	endtask

	task automatic code_download();
		logic [15:0] w [CHEAT_WORDS];
		dl_index  = 8'hFF;
		dl_active = 1'b1;
		step();
		for (int i = 0; i < CHEAT_WORDS; i++) begin
			w[i]    = 16'($urandom);
			dl_addr = 25'h40 + 25'(2 * i);
			dl_data = w[i];
			dl_wr   = 1'b1;
			if (i == CHEAT_WORDS - 1) mon.push_cheat(expected_cheat(w), mon.cyc + 1);
			step();
			dl_wr = 1'b0;
		end
		repeat (3) step();
		dl_active = 1'b0;
		step();
	endtask

	task automatic expect_transfer(input logic load);
		for (int i = 0; i < BK_SECTORS; i++) begin
			mon.push_sector('{rd: load, wr: ~load, lba: LBA_W'(i)});
		end
	endtask

	task automatic wait_transfer();
		int n;
		n = 0;
		while (!busy && n < 20) begin
			step();
			n++;
		end
		if (!busy) begin
			$display("Backup transfer never started");
			other_errs++;
		end
		n = 0;
		while (busy && n < BK_SECTORS * MAX_SECTOR_CYC) begin
			step();
			n++;
		end
		if (busy) begin
			$display("Backup transfer did not finish, busy still high");
			other_errs++;
		end
	endtask

	// Host sector side, random ack delay and hold
	initial begin
		sd_ack = 1'b0;
		forever begin
			step();
			if ((sd.rd | sd.wr) && !sd_ack) begin
				repeat ($urandom_range(1, 6) - 1) step();
				sd_ack = 1'b1;
				repeat ($urandom_range(2, 4)) step();
				sd_ack = 1'b0;
			end
		end
	end

	//////////////////////////////
	// Main sequence
	initial begin
		logic [7:0] c0;
		logic [7:0] c1;
		logic [7:0] c2;
		region_t    r;
		void'($urandom(32'h304e2784));
		RESET = 1'b1;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		dl_index = '0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_present = 1'b0;
		bk_load = 1'b0;
		bk_save = 1'b0;
		auto_region = 1'b1;
		region_from_hdr = 1'b1;
		region_prio = PRIO_US_EU_JP;
		repeat (3) @(posedge clk_sys);
		#10;
		RESET = 1'b0;
		step();

		// Letters under every priority order
		for (int p = 0; p < 4; p++) begin
			region_prio = prio_t'(p);
			for (int m = 0; m < 8; m++) begin
				c0 = m[0] ? "J" : " ";
				c1 = m[1] ? "U" : " ";
				c2 = m[2] ? "E" : " ";
				r  = expected_region(c0, c1, c2, region_prio);
				cart_download(8'h00, {c1, c0}, {8'h20, c2}, 1'b0, 1'b1, r);
			end
		end

		// Digit and hex codes
		for (int i = 0; i < 16; i++) begin
			c0 = (i < 10) ? 8'("0" + i) : 8'("A" + i - 10);
			region_prio = prio_t'($urandom_range(0, 3));
			r = expected_region(c0, " ", " ", region_prio);
			cart_download(8'h00, {8'h20, c0}, 16'h2020, 1'b0, 1'b1, r);
		end

		// Region from the download index
		region_from_hdr = 1'b0;
		for (int i = 0; i < 3; i++) begin
			cart_download(8'(i << 6), "UJ", "E ", 1'b0, i != 0, region_t'(i));
		end
		region_from_hdr = 1'b1;

		repeat (3) code_download();

		// Load after a download with a writable image
		auto_region = 1'b0;
		img_present = 1'b1;
		expect_transfer(1'b1);
		cart_download(8'h00, "  ", "  ", 1'b1, 1'b0, REGION_JP);
		wait_transfer();

		// Save on request
		expect_transfer(1'b0);
		bk_save = 1'b1;
		repeat (3) step();
		bk_save = 1'b0;
		wait_transfer();

		// No image, no request
		img_present = 1'b0;
		cart_download(8'h00, "  ", "  ", 1'b0, 1'b0, REGION_JP);
		bk_save = 1'b1;
		repeat (3) step();
		bk_save = 1'b0;
		repeat (20) step();
		if (busy) begin
			$display("Save started without a mounted image");
			other_errs++;
		end

		repeat (10) step();
		if (mon.pending() != 0) begin
			$display("Expected responses never arrived, %0d left", mon.pending());
			other_errs++;
		end
		$display("Errors: region %0d cheat %0d sector %0d other %0d",
			mon.region_errs, mon.cheat_errs, mon.sd_errs, other_errs);
		if (mon.region_errs + mon.cheat_errs + mon.sd_errs + other_errs == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
cart_pkg.sv
sector_counter.sv
header_region.sv
cheat_loader.sv
backup_fsm.sv
cart_loader.sv
cart_loader_checker.sv
cart_monitor.sv
tb_cart_loader.sv

//--- Makefile
SRCS := $(shell cat sim.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_cart_loader: sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cart_loader -f sim.f

run: obj_dir/Vtb_cart_loader
	./obj_dir/Vtb_cart_loader | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log
